//--- compile.f
design/busMapPkg.sv
design/samplePkg.sv
design/busDecode.sv
design/miscTimer.sv
design/dacOutputStage.sv
design/trellisTop.sv
testbench/tbTrellisTop.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tbTrellisTop
FILELIST  ?= compile.f
LOG       ?= sim.log
BUILD_DIR ?= obj_dir
PASS_MSG  := *** TEST PASSED ***

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary --timing --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -qF "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- testbench/tbTrellisTop.sv
`timescale 1ns/1ps
`default_nettype none

module tbTrellisTop;

  import busMapPkg::*;
  import samplePkg::*;

  // Select codes stepped through by the source selection test
  localparam logic [selW-1:0] selCodes [7] = '{4'd12, 4'd13, 4'd14, 4'd15, 4'd0, 4'd6, 4'd11};

  logic                      ck933 = 1'b0;
  logic                      clockCounterEn;
  logic [busAddrW-1:0]       wbAdr;
  logic [busDataW-1:0]       wbDatW;
  logic [busDataW-1:0]       wbDatR;
  logic                      wbWe;
  logic                      wbStb;
  logic                      wbCyc;
  logic                      wbAck;
  logic signed [sampleW-1:0] demodData [numDacs];
  logic signed [sampleW-1:0] pcmData [numDacs];
  logic signed [sampleW-1:0] soqpskData [numDacs];
  logic [numDacs-1:0]        demodSync;
  logic [numDacs-1:0]        pcmSync;
  logic [numDacs-1:0]        soqpskSync;
  logic [dacW-1:0]           dacData [numDacs];
  logic                      dacRst;

  integer           seed = 32'he1303ca3;
  logic             stimOn = 1'b0;
  logic             trackOn = 1'b0;
  logic             rstWatch = 1'b0;
  logic [modeW-1:0] shadowMode;
  logic [selW-1:0]  shadowSel [numDacs];
  int               testErrors = 0;
  int               cmpErrors = 0;
  int               passCount = 0;
  int               failCount = 0;

  // Compare pipeline state
  logic [dacW-1:0]  expWord [numDacs];
  logic [dacW-1:0]  pipeWord [numDacs][2];
  logic             pipeValid [numDacs][2];
  logic             rstWatchQ = 1'b0;
  logic             rstPrev = 1'b0;
  int               rstHigh = 0;
  int               rstRuns = 0;

  always #10 ck933 = ~ck933;

  trellisTop UUT (
    .ck933          (ck933),
    .clockCounterEn (clockCounterEn),
    .wbAdr_i        (wbAdr),
    .wbDat_i        (wbDatW),
    .wbDat_o        (wbDatR),
    .wbWe_i         (wbWe),
    .wbStb_i        (wbStb),
    .wbCyc_i        (wbCyc),
    .wbAck_o        (wbAck),
    .demodData_i    (demodData),
    .demodSync_i    (demodSync),
    .pcmData_i      (pcmData),
    .pcmSync_i      (pcmSync),
    .soqpskData_i   (soqpskData),
    .soqpskSync_i   (soqpskSync),
    .dacData_o      (dacData),
    .dacRst_o       (dacRst)
  );

  //********************
  // Reference model
  //********************
  // Trellis codes are 12 and up, PCM trellis mode is 7
  function automatic logic [dacW-1:0] refDacWord(input logic [selW-1:0] sel,
                                                 input logic [modeW-1:0] mode,
                                                 input logic [sampleW-1:0] dSample,
                                                 input logic [sampleW-1:0] pSample,
                                                 input logic [sampleW-1:0] sSample);
    logic [sampleW-1:0] chosen;
    if (sel < 4'd12) begin
      chosen = dSample;
    end else if (mode == 4'd7) begin
      chosen = pSample;
    end else begin
      chosen = sSample;
    end
    // Flip the sign bit for offset binary
    return chosen[sampleW-1:dacLsb] ^ 14'h2000;
  endfunction

  function automatic logic refSync(input logic [selW-1:0] sel, input logic [modeW-1:0] mode,
                                   input logic dSync, input logic pSync, input logic sSync);
    if (sel < 4'd12) begin
      return dSync;
    end
    return (mode == 4'd7) ? pSync : sSync;
  endfunction

  //********************
  // Sample stimulus
  //********************
  initial begin
    logic [31:0] rnd;
    logic        go;
    for (int ch = 0; ch < numDacs; ch++) begin
      demodData[ch]  <= '0;
      pcmData[ch]    <= '0;
      soqpskData[ch] <= '0;
    end
    demodSync  <= '0;
    pcmSync    <= '0;
    soqpskSync <= '0;
    forever begin
      @(negedge ck933);
      go = stimOn;
      @(posedge ck933);
      for (int ch = 0; ch < numDacs; ch++) begin
        if (go) begin
          rnd = $random(seed);
          demodData[ch] <= rnd[sampleW-1:0];
          rnd = $random(seed);
          pcmData[ch] <= rnd[sampleW-1:0];
          rnd = $random(seed);
          soqpskData[ch] <= rnd[sampleW-1:0];
          rnd = $random(seed);
          demodSync[ch]  <= rnd[0];
          pcmSync[ch]    <= rnd[1];
          soqpskSync[ch] <= rnd[2];
        end else begin
          demodSync[ch]  <= 1'b0;
          pcmSync[ch]    <= 1'b0;
          soqpskSync[ch] <= 1'b0;
        end
      end
    end
  end

  //********************
  // Output comparison
  //********************
  // Word seen at a negedge comes from the inputs two negedges earlier
  always @(negedge ck933) begin
    if (rstWatch && !rstWatchQ) begin
      rstHigh = 0;
      rstRuns = 0;
    end
    if (rstWatch && dacRst) begin
      rstHigh++;
      if (!rstPrev) begin
        rstRuns++;
      end
    end
    if (!rstWatch && dacRst) begin
      $display("dacRst_o went high without a soft reset request at %0t", $time);
      cmpErrors++;
    end
    for (int ch = 0; ch < numDacs; ch++) begin
      if (!trackOn) begin
        expWord[ch]      = 14'h2000;
        pipeValid[ch][0] = 1'b0;
        pipeValid[ch][1] = 1'b0;
      end else begin
        if (pipeValid[ch][1]) begin
          expWord[ch] = pipeWord[ch][1];
        end
        if (dacData[ch] !== expWord[ch]) begin
          $display("[ERROR] dacData_o[%0d] expected %h got %h at %0t",
                   ch, expWord[ch], dacData[ch], $time);
          cmpErrors++;
        end
        pipeWord[ch][1]  = pipeWord[ch][0];
        pipeValid[ch][1] = pipeValid[ch][0];
        pipeWord[ch][0]  = refDacWord(shadowSel[ch], shadowMode, demodData[ch],
                                      pcmData[ch], soqpskData[ch]);
        pipeValid[ch][0] = refSync(shadowSel[ch], shadowMode, demodSync[ch],
                                   pcmSync[ch], soqpskSync[ch]);
      end
      if (rstWatch && dacRst && dacData[ch] !== 14'h2000) begin
        $display("[ERROR] dacData_o[%0d] expected 2000 got %h during soft reset",
                 ch, dacData[ch]);
        cmpErrors++;
      end
    end
    rstPrev   = dacRst;
    rstWatchQ = rstWatch;
  end

  //********************
  // Bus and check helpers
  //********************
  task automatic busXfer(input logic [busAddrW-1:0] addr, input logic write,
                         input logic [busDataW-1:0] wdata, output logic [busDataW-1:0] rdata);
    int waitCnt;
    @(posedge ck933);
    wbCyc  <= 1'b1;
    wbStb  <= 1'b1;
    wbWe   <= write;
    wbAdr  <= addr;
    wbDatW <= wdata;
    waitCnt = 0;
    @(negedge ck933);
    while (!wbAck && waitCnt < 16) begin
      @(negedge ck933);
      waitCnt++;
    end
    rdata = wbDatR;
    if (!wbAck) begin
      $display("Bus access to address %h was never acknowledged", addr);
      testErrors++;
    end
    @(posedge ck933);
    wbCyc <= 1'b0;
    wbStb <= 1'b0;
    wbWe  <= 1'b0;
  endtask

  task automatic busWrite(input logic [busAddrW-1:0] addr, input logic [busDataW-1:0] data);
    logic [busDataW-1:0] unused;
    busXfer(addr, 1'b1, data, unused);
  endtask

  task automatic busRead(input logic [busAddrW-1:0] addr, output logic [busDataW-1:0] data);
    busXfer(addr, 1'b0, '0, data);
  endtask

  task automatic writeSel(input int ch, input logic [busDataW-1:0] data);
    busWrite(regDac0Sel + busAddrW'(ch), data);
    shadowSel[ch] = data[selW-1:0];
  endtask

  task automatic writeMode(input logic [busDataW-1:0] data);
    busWrite(regDemodMode, data);
    shadowMode = data[modeW-1:0];
  endtask

  task automatic readCount(output logic [counterW-1:0] count);
    logic [busDataW-1:0] lo;
    logic [busDataW-1:0] hi;
    busRead(regClockLo, lo);
    busRead(regClockHi, hi);
    count = {hi, lo};
  endtask

  task automatic checkValue(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("[ERROR] %s expected %h got %h at %0t", name, exp, got, $time);
      testErrors++;
    end
  endtask

  task automatic finishTest(input string name, input int errBase);
    int newErrors;
    newErrors = testErrors + cmpErrors - errBase;
    if (newErrors == 0) begin
      $display("Test %s: ok", name);
      passCount++;
    end else begin
      $display("Test %s: %0d errors", name, newErrors);
      failCount++;
    end
  endtask

  task automatic runSamples(input int cycles);
    stimOn = 1'b1;
    repeat (cycles) @(posedge ck933);
    stimOn = 1'b0;
    repeat (4) @(posedge ck933);
  endtask

  //********************
  // Test sequence
  //********************
  initial begin
    logic [31:0]         rnd;
    logic [busDataW-1:0] rdData;
    logic [counterW-1:0] firstCount;
    logic [counterW-1:0] secondCount;
    int                  idle;
    int                  errBase;
    clockCounterEn <= 1'b1;
    wbAdr  <= '0;
    wbDatW <= '0;
    wbWe   <= 1'b0;
    wbStb  <= 1'b0;
    wbCyc  <= 1'b0;
    shadowMode = '0;
    for (int ch = 0; ch < numDacs; ch++) begin
      shadowSel[ch] = '0;
    end
    repeat (4) @(posedge ck933);
    clockCounterEn <= 1'b0;
    @(posedge ck933);
    trackOn = 1'b1;

    // Reset state
    errBase = testErrors + cmpErrors;
    @(negedge ck933);
    checkValue("wbAck_o", 32'(wbAck), 32'h0);
    checkValue("dacRst_o", 32'(dacRst), 32'h0);
    for (int ch = 0; ch < numDacs; ch++) begin
      checkValue("dacData_o", 32'(dacData[ch]), 32'h2000);
    end
    finishTest("reset state", errBase);

    // Register access
    errBase = testErrors + cmpErrors;
    busRead(regVersion, rdData);
    checkValue("wbDat_o", 32'(rdData), 32'h00a4);
    rnd = $random(seed);
    writeMode(rnd[busDataW-1:0]);
    busRead(regDemodMode, rdData);
    checkValue("wbDat_o", 32'(rdData), 32'(rnd[3:0]));
    for (int ch = 0; ch < numDacs; ch++) begin
      rnd = $random(seed);
      writeSel(ch, rnd[busDataW-1:0]);
      busRead(regDac0Sel + busAddrW'(ch), rdData);
      checkValue("wbDat_o", 32'(rdData), 32'(rnd[3:0]));
    end
    busRead(4'hc, rdData);
    checkValue("wbDat_o", 32'(rdData), 32'h0);
    finishTest("register access", errBase);

    // Source selection and formatting over every code and both trellis modes
    errBase = testErrors + cmpErrors;
    for (int m = 0; m < 2; m++) begin
      for (int step = 0; step < 7; step++) begin
        writeMode((m == 0) ? 16'd7 : 16'd8);
        for (int ch = 0; ch < numDacs; ch++) begin
          writeSel(ch, 16'(selCodes[(3 * step + ch) % 7]));
        end
        runSamples(40);
      end
    end
    finishTest("dac selection", errBase);

    // Clock counter
    errBase = testErrors + cmpErrors;
    rnd  = $random(seed);
    idle = 20 + int'(rnd[5:0]);
    busWrite(regClockStart, 16'h0001);
    repeat (idle) @(posedge ck933);
    busWrite(regClockCapture, 16'h0001);
    readCount(firstCount);
    if (firstCount < 32'(idle) || firstCount >= 32'(idle + 16)) begin
      $display("[ERROR] heldCount expected %h to %h got %h", idle, idle + 15, firstCount);
      testErrors++;
    end
    busWrite(regClockStart, 16'h0001);
    repeat (idle / 2) @(posedge ck933);
    busWrite(regClockCapture, 16'h0001);
    readCount(secondCount);
    if (secondCount >= firstCount) begin
      $display("[ERROR] heldCount expected below %h got %h", firstCount, secondCount);
      testErrors++;
    end
    finishTest("clock counter", errBase);

    // Soft reset, with every control register nonzero beforehand
    errBase  = testErrors + cmpErrors;
    writeSel(0, 16'd5);
    trackOn  = 1'b0;
    rstWatch = 1'b1;
    busRead(regSoftReset, rdData);
    repeat (16) @(posedge ck933);
    rstWatch = 1'b0;
    @(posedge ck933);
    checkValue("dacRst_o high cycles", 32'(rstHigh), 32'd6);
    if (rstRuns != 1) begin
      $display("dacRst_o did not form a single pulse, %0d pulses seen", rstRuns);
      testErrors++;
    end
    busRead(regDemodMode, rdData);
    checkValue("wbDat_o", 32'(rdData), 32'(shadowMode));
    for (int ch = 0; ch < numDacs; ch++) begin
      busRead(regDac0Sel + busAddrW'(ch), rdData);
      checkValue("wbDat_o", 32'(rdData), 32'(shadowSel[ch]));
    end
    trackOn = 1'b1;
    writeMode(16'd7);
    writeSel(0, 16'd12);
    writeSel(1, 16'd3);
    writeSel(2, 16'd15);
    runSamples(40);
    finishTest("soft reset", errBase);

    $display("Tests passed: %0d, tests failed: %0d", passCount, failCount);
    if (failCount == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- design/trellisTop.sv
`timescale 1ns/1ps
`default_nettype none

module trellisTop (
  input  logic                                 ck933,
  input  logic                                 clockCounterEn,
  // Wishbone
  input  logic [busMapPkg::busAddrW-1:0]       wbAdr_i,
  input  logic [busMapPkg::busDataW-1:0]       wbDat_i,
  output logic [busMapPkg::busDataW-1:0]       wbDat_o,
  input  logic                                 wbWe_i,
  input  logic                                 wbStb_i,
  input  logic                                 wbCyc_i,
  output logic                                 wbAck_o,
  // Monitor samples
  input  logic signed [samplePkg::sampleW-1:0] demodData_i [samplePkg::numDacs],
  input  logic [samplePkg::numDacs-1:0]        demodSync_i,
  input  logic signed [samplePkg::sampleW-1:0] pcmData_i [samplePkg::numDacs],
  input  logic [samplePkg::numDacs-1:0]        pcmSync_i,
  input  logic signed [samplePkg::sampleW-1:0] soqpskData_i [samplePkg::numDacs],
  input  logic [samplePkg::numDacs-1:0]        soqpskSync_i,
  // DAC
  output logic [samplePkg::dacW-1:0]           dacData_o [samplePkg::numDacs],
  output logic                                 dacRst_o
);

  import busMapPkg::*;
  import samplePkg::*;

  logic [counterW-1:0] heldCount;
  logic                softReset;
  logic                clockStart;
  logic                clockCapture;
  logic                resetReq;
  logic [modeW-1:0]    demodMode;
  logic [selW-1:0]     dacSel [numDacs];

  //********************
  // Processor bus
  //********************
  busDecode busDecodeInst (
    .ck933          (ck933),
    .clockCounterEn (clockCounterEn),
    .wbAdr_i        (wbAdr_i),
    .wbDat_i        (wbDat_i),
    .wbWe_i         (wbWe_i),
    .wbStb_i        (wbStb_i),
    .wbCyc_i        (wbCyc_i),
    .heldCount_i    (heldCount),
    .wbDat_o        (wbDat_o),
    .wbAck_o        (wbAck_o),
    .demodMode_o    (demodMode),
    .dacSel_o       (dacSel),
    .clockStart_o   (clockStart),
    .clockCapture_o (clockCapture),
    .resetReq_o     (resetReq)
  );

  miscTimer miscTimerInst (
    .ck933          (ck933),
    .clockCounterEn (clockCounterEn),
    .clockStart_i   (clockStart),
    .clockCapture_i (clockCapture),
    .resetReq_i     (resetReq),
    .heldCount_o    (heldCount),
    .softReset_o    (softReset)
  );

  assign dacRst_o = softReset;

  //********************
  // DAC channels
  //********************
  for (genvar g = 0; g < numDacs; g++) begin : genDac
    dacOutputStage dacStage (
      .ck933          (ck933),
      .clockCounterEn (clockCounterEn),
      .softReset_i    (softReset),
      .dacSel_i       (dacSel[g]),
      .demodMode_i    (demodMode),
      .demodData_i    (demodData_i[g]),
      .demodSync_i    (demodSync_i[g]),
      .pcmData_i      (pcmData_i[g]),
      .pcmSync_i      (pcmSync_i[g]),
      .soqpskData_i   (soqpskData_i[g]),
      .soqpskSync_i   (soqpskSync_i[g]),
      .dacData_o      (dacData_o[g])
    );
  end

endmodule

`default_nettype wire

//--- design/dacOutputStage.sv
`timescale 1ns/1ps
`default_nettype none

module dacOutputStage (
  input  logic                                ck933,
  input  logic                                clockCounterEn,
  input  logic                                softReset_i,
  input  logic [samplePkg::selW-1:0]          dacSel_i,
  input  logic [samplePkg::modeW-1:0]         demodMode_i,
  input  logic signed [samplePkg::sampleW-1:0] demodData_i,
  input  logic                                demodSync_i,
  input  logic signed [samplePkg::sampleW-1:0] pcmData_i,
  input  logic                                pcmSync_i,
  input  logic signed [samplePkg::sampleW-1:0] soqpskData_i,
  input  logic                                soqpskSync_i,
  output logic [samplePkg::dacW-1:0]          dacData_o
);

  import samplePkg::*;

  logic                      isTrellis;
  logic                      pcmMode;
  logic signed [sampleW-1:0] selData;
  logic                      selSync;
  logic signed [sampleW-1:0] sampleReg;
  logic                      syncReg;
  logic [dacW-1:0]           dacWord;

  //********************
  // Source selection
  //********************
  assign isTrellis = (dacSel_i == dacTrellisI) || (dacSel_i == dacTrellisQ) ||
                     (dacSel_i == dacTrellisPhErr) || (dacSel_i == dacTrellisIndex);
  assign pcmMode   = (demodMode_i == modePcmTrellis);

  always_comb begin
    if (!isTrellis) begin
      selData = demodData_i;
      selSync = demodSync_i;
    end else if (pcmMode) begin
      selData = pcmData_i;
      selSync = pcmSync_i;
    end else begin
      selData = soqpskData_i;
      selSync = soqpskSync_i;
    end
  end

  // Stage 1 sample
  always_ff @(posedge ck933 or posedge clockCounterEn) begin
    if (clockCounterEn) begin
      sampleReg <= '0;
    end else if (softReset_i) begin
      sampleReg <= '0;
    end else begin
      sampleReg <= selData;
    end
  end

  // Stage 1 sync, stage 2 word
  always_ff @(posedge ck933 or posedge clockCounterEn) begin
    if (clockCounterEn) begin
      syncReg <= 1'b0;
      dacWord <= dacMidscale;
    end else if (softReset_i) begin
      syncReg <= 1'b0;
      dacWord <= dacMidscale;
    end else begin
      syncReg <= selSync;
      // Two's complement to offset binary
      if (syncReg) begin
        dacWord <= {~sampleReg[sampleW-1], sampleReg[sampleW-2:dacLsb]};
      end
    end
  end

  // DAC parks at midscale for the whole soft reset
  assign dacData_o = softReset_i ? dacMidscale : dacWord;

endmodule

`default_nettype wire

//--- design/miscTimer.sv
`timescale 1ns/1ps
`default_nettype none

module miscTimer (
  input  logic                           ck933,
  input  logic                           clockCounterEn,
  input  logic                           clockStart_i,
  input  logic                           clockCapture_i,
  input  logic                           resetReq_i,
  output logic [busMapPkg::counterW-1:0] heldCount_o,
  output logic                           softReset_o
);

  import busMapPkg::*;

  localparam int resetCntW = $clog2(softResetCycles + 1);

  logic [counterW-1:0]  clockCounter;
  logic [resetCntW-1:0] resetCnt;

  //********************
  // Cycle counter
  //********************
  // Restarts from zero on a start pulse, otherwise free-runs
  always_ff @(posedge ck933 or posedge clockCounterEn) begin
    if (clockCounterEn) begin
      clockCounter <= '0;
    end else if (clockStart_i) begin
      clockCounter <= '0;
    end else begin
      clockCounter <= clockCounter + counterW'(1);
    end
  end

  // Snapshot for the processor
  always_ff @(posedge ck933 or posedge clockCounterEn) begin
    if (clockCounterEn) begin
      heldCount_o <= '0;
    end else if (clockCapture_i) begin
      heldCount_o <= clockCounter;
    end
  end

  //********************
  // Soft reset sequencer
  //********************
  // Loaded on request, counts down to zero
  always_ff @(posedge ck933 or posedge clockCounterEn) begin
    if (clockCounterEn) begin
      resetCnt <= '0;
    end else if (resetReq_i) begin
      resetCnt <= resetCntW'(softResetCycles);
    end else if (resetCnt != '0) begin
      resetCnt <= resetCnt - resetCntW'(1);
    end
  end

  // High for one cycle per count loaded
  assign softReset_o = (resetCnt != '0);

endmodule

`default_nettype wire

//--- design/busDecode.sv
`timescale 1ns/1ps
`default_nettype none

module busDecode (
  input  logic                              ck933,
  input  logic                              clockCounterEn,
  input  logic [busMapPkg::busAddrW-1:0]    wbAdr_i,
  input  logic [busMapPkg::busDataW-1:0]    wbDat_i,
  input  logic                              wbWe_i,
  input  logic                              wbStb_i,
  input  logic                              wbCyc_i,
  input  logic [busMapPkg::counterW-1:0]    heldCount_i,
  output logic [busMapPkg::busDataW-1:0]    wbDat_o,
  output logic                              wbAck_o,
  output logic [samplePkg::modeW-1:0]       demodMode_o,
  output logic [samplePkg::selW-1:0]        dacSel_o [samplePkg::numDacs],
  output logic                              clockStart_o,
  output logic                              clockCapture_o,
  output logic                              resetReq_o
);

  import busMapPkg::*;
  import samplePkg::*;

  logic                xferGo;
  logic                wrEn;
  logic                rdEn;
  logic [busDataW-1:0] readMux;

  // One wait state, so the transfer is taken only on the cycle ack rises
  assign xferGo = wbCyc_i && wbStb_i && !wbAck_o;
  assign wrEn   = xferGo && wbWe_i;
  assign rdEn   = xferGo && !wbWe_i;

  //********************
  // Read mux
  //********************
  always_comb begin
    case (wbAdr_i)
      regVersion:   readMux = versionNumber;
      regDemodMode: readMux = busDataW'(demodMode_o);
      regDac0Sel:   readMux = busDataW'(dacSel_o[0]);
      regDac1Sel:   readMux = busDataW'(dacSel_o[1]);
      regDac2Sel:   readMux = busDataW'(dacSel_o[2]);
      regClockLo:   readMux = heldCount_i[busDataW-1:0];
      regClockHi:   readMux = heldCount_i[counterW-1:busDataW];
      default:      readMux = '0;
    endcase
  end

  //********************
  // Acknowledge, read data and command pulses
  //********************
  always_ff @(posedge ck933 or posedge clockCounterEn) begin
    if (clockCounterEn) begin
      wbAck_o        <= 1'b0;
      wbDat_o        <= '0;
      clockStart_o   <= 1'b0;
      clockCapture_o <= 1'b0;
      resetReq_o     <= 1'b0;
    end else begin
      wbAck_o        <= xferGo;
      wbDat_o        <= rdEn ? readMux : '0;
      clockStart_o   <= wrEn && (wbAdr_i == regClockStart);
      clockCapture_o <= wrEn && (wbAdr_i == regClockCapture);
      // Soft reset is triggered by a read, not a write
      resetReq_o     <= rdEn && (wbAdr_i == regSoftReset);
    end
  end

  //********************
  // Control registers
  //********************
  always_ff @(posedge ck933 or posedge clockCounterEn) begin
    if (clockCounterEn) begin
      demodMode_o <= '0;
      for (int i = 0; i < numDacs; i++) begin
        dacSel_o[i] <= '0;
      end
    end else if (wrEn) begin
      case (wbAdr_i)
        regDemodMode: demodMode_o <= wbDat_i[modeW-1:0];
        regDac0Sel:   dacSel_o[0] <= wbDat_i[selW-1:0];
        regDac1Sel:   dacSel_o[1] <= wbDat_i[selW-1:0];
        regDac2Sel:   dacSel_o[2] <= wbDat_i[selW-1:0];
        default: ;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- design/samplePkg.sv
`default_nettype none

package samplePkg;

  // Monitor sample and DAC word sizes
  localparam int sampleW = 18;
  localparam int dacW    = 14;
  localparam int dacLsb  = 4;
  localparam int numDacs = 3;

  localparam int selW  = 4;
  localparam int modeW = 4;

  //********************
  // DAC monitor select codes
  //********************
  // Anything outside 12..15 picks the demodulator monitor
  localparam logic [selW-1:0] dacTrellisI     = 4'd12;
  localparam logic [selW-1:0] dacTrellisQ     = 4'd13;
  localparam logic [selW-1:0] dacTrellisPhErr = 4'd14;
  localparam logic [selW-1:0] dacTrellisIndex = 4'd15;

  // Demodulator modes that own a trellis decoder
  localparam logic [modeW-1:0] modePcmTrellis = 4'd7;
  localparam logic [modeW-1:0] modeSoqpsk     = 4'd8;

  // Offset-binary zero
  localparam logic [dacW-1:0] dacMidscale = 14'h2000;

endpackage

`default_nettype wire

//--- design/busMapPkg.sv
`default_nettype none

package busMapPkg;

  // Control bus geometry
  localparam int busDataW = 16;
  localparam int busAddrW = 4;

  //********************
  // Register word addresses
  //********************
  localparam logic [busAddrW-1:0] regVersion      = 4'd0;
  localparam logic [busAddrW-1:0] regDemodMode    = 4'd1;
  localparam logic [busAddrW-1:0] regDac0Sel      = 4'd2;
  localparam logic [busAddrW-1:0] regDac1Sel      = 4'd3;
  localparam logic [busAddrW-1:0] regDac2Sel      = 4'd4;
  localparam logic [busAddrW-1:0] regClockStart   = 4'd5;
  localparam logic [busAddrW-1:0] regClockCapture = 4'd6;
  localparam logic [busAddrW-1:0] regClockLo      = 4'd7;
  localparam logic [busAddrW-1:0] regClockHi      = 4'd8;
  localparam logic [busAddrW-1:0] regSoftReset    = 4'd9;

  // Returned by a read of regVersion
  localparam logic [15:0] versionNumber = 16'h00a4;

  // Soft reset length in ck933 cycles
  localparam int softResetCycles = 6;

  // Free-running clock counter
  localparam int counterW = 32;

endpackage

`default_nettype wire
